// File: src/rv_exec_pkg.sv
package rv_exec_pkg;

	localparam int XLEN = 32;

	// major opcodes.
	localparam logic [6:0] OP_R   = 7'b0110011;
	localparam logic [6:0] OP_I   = 7'b0010011;
	localparam logic [6:0] OP_IL  = 7'b0000011;
	localparam logic [6:0] OP_S   = 7'b0100011;
	localparam logic [6:0] OP_B   = 7'b1100011;
	localparam logic [6:0] OP_J   = 7'b1101111;
	localparam logic [6:0] OP_JR  = 7'b1100111;
	localparam logic [6:0] OP_U   = 7'b0110111;
	localparam logic [6:0] OP_UPC = 7'b0010111;

	localparam logic [2:0] F3_ADDSUB = 3'b000;
	localparam logic [2:0] F3_SLL    = 3'b001;
	localparam logic [2:0] F3_SLT    = 3'b010;
	localparam logic [2:0] F3_SLTU   = 3'b011;
	localparam logic [2:0] F3_XOR    = 3'b100;
	localparam logic [2:0] F3_SR     = 3'b101;
	localparam logic [2:0] F3_OR     = 3'b110;
	localparam logic [2:0] F3_AND    = 3'b111;

	localparam logic [2:0] F3_B  = 3'b000; // load/store widths.
	localparam logic [2:0] F3_H  = 3'b001;
	localparam logic [2:0] F3_W  = 3'b010;
	localparam logic [2:0] F3_BU = 3'b100;
	localparam logic [2:0] F3_HU = 3'b101;

	localparam logic [2:0] F3_BEQ  = 3'b000;
	localparam logic [2:0] F3_BNE  = 3'b001;
	localparam logic [2:0] F3_BLT  = 3'b100;
	localparam logic [2:0] F3_BGE  = 3'b101;
	localparam logic [2:0] F3_BLTU = 3'b110;
	localparam logic [2:0] F3_BGEU = 3'b111;

	localparam logic [6:0] F7_ALT = 7'b0100000; // sub and sra.

	localparam logic [3:0] ALU_ADD  = {1'b0, F3_ADDSUB};
	localparam logic [3:0] ALU_SUB  = {1'b1, F3_ADDSUB};
	localparam logic [3:0] ALU_SLL  = {1'b0, F3_SLL};
	localparam logic [3:0] ALU_SLT  = {1'b0, F3_SLT};
	localparam logic [3:0] ALU_SLTU = {1'b0, F3_SLTU};
	localparam logic [3:0] ALU_XOR  = {1'b0, F3_XOR};
	localparam logic [3:0] ALU_SRL  = {1'b0, F3_SR};
	localparam logic [3:0] ALU_SRA  = {1'b1, F3_SR};
	localparam logic [3:0] ALU_OR   = {1'b0, F3_OR};
	localparam logic [3:0] ALU_AND  = {1'b0, F3_AND};

	// decoded op is {pc, imm, op, rd, rs1, rs2, func3}.
	localparam int OPC_BITS   = 7;
	localparam int REG_BITS   = 5;
	localparam int FUNC3_BITS = 3;
	localparam int OP_BITS    = 2 * XLEN + OPC_BITS + 3 * REG_BITS + FUNC3_BITS;
	localparam int F3_LSB  = 0;
	localparam int RS2_LSB = F3_LSB + FUNC3_BITS;
	localparam int RS1_LSB = RS2_LSB + REG_BITS;
	localparam int RD_LSB  = RS1_LSB + REG_BITS;
	localparam int OPC_LSB = RD_LSB + REG_BITS;
	localparam int IMM_LSB = OPC_LSB + OPC_BITS;
	localparam int PC_LSB  = IMM_LSB + XLEN;

	localparam int QUEUE_DEPTH = 4;
	localparam int MEM_WORDS   = 256;

endpackage

// File: src/inst_decoder.sv
`timescale 1ns/1ns

module inst_decoder (
	input  logic                              clk,
	input  logic                              rst,
	input  logic                              inst_valid,
	input  logic [31:0]                       inst,
	input  logic [rv_exec_pkg::XLEN-1:0]      inst_pc,
	output logic                              dec_valid,
	output logic [rv_exec_pkg::OP_BITS-1:0]   dec_op
);

	logic [6:0]                         opcode;
	logic [4:0]                         rd;
	logic [4:0]                         rs1;
	logic [4:0]                         rs2;
	logic [2:0]                         func3;
	logic [rv_exec_pkg::XLEN-1:0]       imm;

	assign opcode = inst[6:0];
	assign rd     = inst[11:7];
	assign func3  = inst[14:12];
	assign rs1    = inst[19:15];
	assign rs2    = inst[24:20];

	always_comb begin
		case (opcode)
			rv_exec_pkg::OP_S:
				imm = {{20{inst[31]}}, inst[31:25], inst[11:7]};
			rv_exec_pkg::OP_B:
				imm = {{19{inst[31]}}, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};
			rv_exec_pkg::OP_U,
			rv_exec_pkg::OP_UPC:
				imm = {inst[31:12], 12'b0};
			rv_exec_pkg::OP_J:
				imm = {{11{inst[31]}}, inst[31], inst[19:12], inst[20], inst[30:21], 1'b0};
			// I format, also for R so func7 lands in imm[11:5].
			default:
				imm = {{20{inst[31]}}, inst[31:20]};
		endcase
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			dec_valid <= 1'b0;
		end else begin
			dec_valid <= inst_valid;
		end
	end

	always_ff @(posedge clk) begin
		if (inst_valid) begin
			dec_op <= {inst_pc, imm, opcode, rd, rs1, rs2, func3};
		end
	end

endmodule

// File: src/issue_queue.sv
`timescale 1ns/1ns

module issue_queue #(
	parameter int WIDTH = 8,
	parameter int DEPTH = 4
) (
	input  logic              clk,
	input  logic              rst,
	input  logic              wr_en,
	input  logic [WIDTH-1:0]  wr_data,
	input  logic              rd_en,
	output logic [WIDTH-1:0]  rd_data,
	output logic              not_empty,
	output logic              credit
);

	localparam int PW = (DEPTH > 1) ? $clog2(DEPTH) : 1;
	localparam int CW = $clog2(DEPTH + 1);

	logic [WIDTH-1:0] mem [DEPTH];
	logic [PW-1:0]    wptr;
	logic [PW-1:0]    rptr;
	logic [CW-1:0]    count;
	logic             pop;

	assign not_empty = (count != '0);
	assign pop       = rd_en & not_empty;
	assign rd_data   = mem[rptr];
	assign credit    = pop; // one slot freed, one credit back.

	always_ff @(posedge clk) begin
		if (wr_en) begin
			mem[wptr] <= wr_data;
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			wptr  <= '0;
			rptr  <= '0;
			count <= '0;
		end else begin
			if (wr_en) begin
				wptr <= (wptr == PW'(DEPTH - 1)) ? '0 : wptr + 1'b1;
			end
			if (pop) begin
				rptr <= (rptr == PW'(DEPTH - 1)) ? '0 : rptr + 1'b1;
			end
			case ({wr_en, pop})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

endmodule

// File: src/alu.sv
`timescale 1ns/1ns

module alu (
	input  logic [rv_exec_pkg::XLEN-1:0] a,
	input  logic [rv_exec_pkg::XLEN-1:0] b,
	input  logic [3:0]                   ctl,
	output logic [rv_exec_pkg::XLEN-1:0] res,
	output logic                         eq,
	output logic                         lt,
	output logic                         ltu
);

	assign eq  = (a == b);
	assign lt  = ($signed(a) < $signed(b));
	assign ltu = (a < b);

	always_comb begin
		case (ctl)
			rv_exec_pkg::ALU_ADD:  res = a + b;
			rv_exec_pkg::ALU_SUB:  res = a - b;
			rv_exec_pkg::ALU_SLL:  res = a << b[4:0];
			rv_exec_pkg::ALU_SLT:  res = {{(rv_exec_pkg::XLEN - 1){1'b0}}, lt};
			rv_exec_pkg::ALU_SLTU: res = {{(rv_exec_pkg::XLEN - 1){1'b0}}, ltu};
			rv_exec_pkg::ALU_XOR:  res = a ^ b;
			rv_exec_pkg::ALU_SRL:  res = a >> b[4:0];
			rv_exec_pkg::ALU_SRA:  res = $signed(a) >>> b[4:0]; // keep sign.
			rv_exec_pkg::ALU_OR:   res = a | b;
			rv_exec_pkg::ALU_AND:  res = a & b;
			default:               res = '0;
		endcase
	end

endmodule

// File: src/reg_file.sv
`timescale 1ns/1ns

module reg_file (
	input  logic                         clk,
	input  logic                         rst,
	input  logic [4:0]                   rs1_addr,
	input  logic [4:0]                   rs2_addr,
	output logic [rv_exec_pkg::XLEN-1:0] rs1_data,
	output logic [rv_exec_pkg::XLEN-1:0] rs2_data,
	input  logic                         wen,
	input  logic [4:0]                   waddr,
	input  logic [rv_exec_pkg::XLEN-1:0] wdata
);

	logic [rv_exec_pkg::XLEN-1:0] regs [32];

	assign rs1_data = regs[rs1_addr];
	assign rs2_data = regs[rs2_addr];

	// x0 is cleared at reset and never written again.
	always_ff @(posedge clk) begin
		if (rst) begin
			for (int i = 0; i < 32; i++) begin
				regs[i] <= '0;
			end
		end else if (wen && waddr != 5'd0) begin
			regs[waddr] <= wdata;
		end
	end

endmodule

// File: src/data_mem.sv
`timescale 1ns/1ns

module data_mem (
	input  logic                         clk,
	input  logic                         wen,
	input  logic [rv_exec_pkg::XLEN-1:0] addr,
	input  logic [3:0]                   wmask,
	input  logic [rv_exec_pkg::XLEN-1:0] wdata,
	output logic [rv_exec_pkg::XLEN-1:0] rdata
);

	localparam int AW = $clog2(rv_exec_pkg::MEM_WORDS);

	logic [rv_exec_pkg::XLEN-1:0] ram [rv_exec_pkg::MEM_WORDS];
	logic [AW-1:0]                word_idx;

	assign word_idx = addr[AW+1:2]; // byte address to word index.
	assign rdata    = ram[word_idx];

	always_ff @(posedge clk) begin
		if (wen) begin
			for (int lane = 0; lane < 4; lane++) begin
				if (wmask[lane]) begin
					ram[word_idx][lane*8 +: 8] <= wdata[lane*8 +: 8];
				end
			end
		end
	end

endmodule

// File: src/exec_unit.sv
`timescale 1ns/1ns

module exec_unit (
	input  logic                              q_valid,
	input  logic [rv_exec_pkg::OP_BITS-1:0]   q_op,
	output logic                              q_pop,
	output logic [4:0]                        rs1_addr,
	output logic [4:0]                        rs2_addr,
	input  logic [rv_exec_pkg::XLEN-1:0]      rs1_data,
	input  logic [rv_exec_pkg::XLEN-1:0]      rs2_data,
	output logic                              gpr_wen,
	output logic [4:0]                        gpr_waddr,
	output logic [rv_exec_pkg::XLEN-1:0]      gpr_wdata,
	output logic                              mem_wen,
	output logic [rv_exec_pkg::XLEN-1:0]      mem_addr,
	output logic [3:0]                        mem_wmask,
	output logic [rv_exec_pkg::XLEN-1:0]      mem_wdata,
	input  logic [rv_exec_pkg::XLEN-1:0]      mem_rdata,
	output logic                              retire_valid,
	output logic [rv_exec_pkg::XLEN-1:0]      retire_pc,
	output logic [4:0]                        retire_rd,
	output logic                              retire_wen,
	output logic [rv_exec_pkg::XLEN-1:0]      retire_wdata,
	output logic                              retire_jump,
	output logic [rv_exec_pkg::XLEN-1:0]      retire_next_pc
);

	logic [rv_exec_pkg::XLEN-1:0] pc;
	logic [rv_exec_pkg::XLEN-1:0] imm;
	logic [6:0]                   op;
	logic [4:0]                   rd;
	logic [2:0]                   func3;
	logic [rv_exec_pkg::XLEN-1:0] snpc;
	logic                         alt;
	logic [3:0]                   alu_ctl;
	logic [rv_exec_pkg::XLEN-1:0] alu_b;
	logic [rv_exec_pkg::XLEN-1:0] alu_res;
	logic                         eq;
	logic                         lt;
	logic                         ltu;
	logic [1:0]                   byte_off;
	logic [rv_exec_pkg::XLEN-1:0] lane;
	logic [rv_exec_pkg::XLEN-1:0] load_data;
	logic [rv_exec_pkg::XLEN-1:0] result;
	logic                         writes_rd;
	logic                         taken;
	logic                         jump;

	assign pc       = q_op[rv_exec_pkg::PC_LSB +: rv_exec_pkg::XLEN];
	assign imm      = q_op[rv_exec_pkg::IMM_LSB +: rv_exec_pkg::XLEN];
	assign op       = q_op[rv_exec_pkg::OPC_LSB +: rv_exec_pkg::OPC_BITS];
	assign rd       = q_op[rv_exec_pkg::RD_LSB +: rv_exec_pkg::REG_BITS];
	assign rs1_addr = q_op[rv_exec_pkg::RS1_LSB +: rv_exec_pkg::REG_BITS];
	assign rs2_addr = q_op[rv_exec_pkg::RS2_LSB +: rv_exec_pkg::REG_BITS];
	assign func3    = q_op[rv_exec_pkg::F3_LSB +: rv_exec_pkg::FUNC3_BITS];

	assign q_pop = q_valid; // never stalls.
	assign snpc  = pc + 32'd4;

	// func7 sits in imm[11:5] for R ops and immediate shifts.
	assign alt = (imm[11:5] == rv_exec_pkg::F7_ALT) &&
		(op == rv_exec_pkg::OP_R || (op == rv_exec_pkg::OP_I && func3 == rv_exec_pkg::F3_SR));

	assign alu_ctl = (op == rv_exec_pkg::OP_R || op == rv_exec_pkg::OP_I) ?
		{alt, func3} : rv_exec_pkg::ALU_ADD;
	assign alu_b = (op == rv_exec_pkg::OP_R || op == rv_exec_pkg::OP_B) ? rs2_data : imm;

	alu u_alu (
		.a   (rs1_data),
		.b   (alu_b),
		.ctl (alu_ctl),
		.res (alu_res),
		.eq  (eq),
		.lt  (lt),
		.ltu (ltu)
	);

	// loads and stores address through the adder.
	assign byte_off  = alu_res[1:0];
	assign mem_addr  = alu_res;
	assign mem_wen   = q_valid && op == rv_exec_pkg::OP_S;
	assign mem_wdata = rs2_data << {byte_off, 3'b000};
	assign lane      = mem_rdata >> {byte_off, 3'b000};

	always_comb begin
		case (func3)
			rv_exec_pkg::F3_B: mem_wmask = 4'b0001 << byte_off;
			rv_exec_pkg::F3_H: mem_wmask = 4'b0011 << byte_off;
			rv_exec_pkg::F3_W: mem_wmask = 4'b1111;
			default:           mem_wmask = 4'b0000;
		endcase
	end

	always_comb begin
		case (func3)
			rv_exec_pkg::F3_B:  load_data = {{24{lane[7]}}, lane[7:0]};
			rv_exec_pkg::F3_H:  load_data = {{16{lane[15]}}, lane[15:0]};
			rv_exec_pkg::F3_BU: load_data = {24'b0, lane[7:0]};
			rv_exec_pkg::F3_HU: load_data = {16'b0, lane[15:0]};
			default:            load_data = mem_rdata;
		endcase
	end

	always_comb begin
		writes_rd = 1'b1;
		case (op)
			rv_exec_pkg::OP_R, rv_exec_pkg::OP_I: result = alu_res;
			rv_exec_pkg::OP_IL:                   result = load_data;
			rv_exec_pkg::OP_U:                    result = imm;
			rv_exec_pkg::OP_UPC:                  result = pc + imm;
			rv_exec_pkg::OP_J, rv_exec_pkg::OP_JR: result = snpc; // link.
			default: begin
				result    = '0;
				writes_rd = 1'b0;
			end
		endcase
	end

	always_comb begin
		case (func3)
			rv_exec_pkg::F3_BEQ:  taken = eq;
			rv_exec_pkg::F3_BNE:  taken = !eq;
			rv_exec_pkg::F3_BLT:  taken = lt;
			rv_exec_pkg::F3_BGE:  taken = !lt;
			rv_exec_pkg::F3_BLTU: taken = ltu;
			rv_exec_pkg::F3_BGEU: taken = !ltu;
			default:              taken = 1'b0;
		endcase
	end

	assign jump = (op == rv_exec_pkg::OP_B && taken) || op == rv_exec_pkg::OP_J ||
		op == rv_exec_pkg::OP_JR;

	assign gpr_wen   = q_valid && writes_rd && rd != 5'd0;
	assign gpr_waddr = rd;
	assign gpr_wdata = result;

	assign retire_valid   = q_pop;
	assign retire_pc      = pc;
	assign retire_rd      = rd;
	assign retire_wen     = gpr_wen;
	assign retire_wdata   = result;
	assign retire_jump    = jump;
	assign retire_next_pc = (op == rv_exec_pkg::OP_JR) ? {alu_res[31:1], 1'b0} :
		jump ? pc + imm : snpc;

endmodule

// File: src/exec_top.sv
`timescale 1ns/1ns

module exec_top (
	input  logic                         clk,
	input  logic                         rst,
	input  logic                         inst_valid,
	input  logic [31:0]                  inst,
	input  logic [rv_exec_pkg::XLEN-1:0] inst_pc,
	output logic                         inst_credit,
	output logic                         retire_valid,
	output logic [rv_exec_pkg::XLEN-1:0] retire_pc,
	output logic [4:0]                   retire_rd,
	output logic                         retire_wen,
	output logic [rv_exec_pkg::XLEN-1:0] retire_wdata,
	output logic                         retire_jump,
	output logic [rv_exec_pkg::XLEN-1:0] retire_next_pc
);

	logic                            dec_valid;
	logic [rv_exec_pkg::OP_BITS-1:0] dec_op;
	logic                            q_valid;
	logic [rv_exec_pkg::OP_BITS-1:0] q_op;
	logic                            q_pop;
	logic [4:0]                      rs1_addr;
	logic [4:0]                      rs2_addr;
	logic [rv_exec_pkg::XLEN-1:0]    rs1_data;
	logic [rv_exec_pkg::XLEN-1:0]    rs2_data;
	logic                            gpr_wen;
	logic [4:0]                      gpr_waddr;
	logic [rv_exec_pkg::XLEN-1:0]    gpr_wdata;
	logic                            mem_wen;
	logic [rv_exec_pkg::XLEN-1:0]    mem_addr;
	logic [3:0]                      mem_wmask;
	logic [rv_exec_pkg::XLEN-1:0]    mem_wdata;
	logic [rv_exec_pkg::XLEN-1:0]    mem_rdata;

	inst_decoder u_dec (
		.clk(clk), .rst(rst), .inst_valid(inst_valid), .inst(inst), .inst_pc(inst_pc),
		.dec_valid(dec_valid), .dec_op(dec_op)
	);

	issue_queue #(
		.WIDTH(rv_exec_pkg::OP_BITS),
		.DEPTH(rv_exec_pkg::QUEUE_DEPTH)
	) u_queue (
		.clk(clk), .rst(rst), .wr_en(dec_valid), .wr_data(dec_op), .rd_en(q_pop),
		.rd_data(q_op), .not_empty(q_valid), .credit(inst_credit)
	);

	exec_unit u_exec (
		.q_valid(q_valid), .q_op(q_op), .q_pop(q_pop),
		.rs1_addr(rs1_addr), .rs2_addr(rs2_addr), .rs1_data(rs1_data), .rs2_data(rs2_data),
		.gpr_wen(gpr_wen), .gpr_waddr(gpr_waddr), .gpr_wdata(gpr_wdata),
		.mem_wen(mem_wen), .mem_addr(mem_addr), .mem_wmask(mem_wmask),
		.mem_wdata(mem_wdata), .mem_rdata(mem_rdata),
		.retire_valid(retire_valid), .retire_pc(retire_pc), .retire_rd(retire_rd),
		.retire_wen(retire_wen), .retire_wdata(retire_wdata), .retire_jump(retire_jump),
		.retire_next_pc(retire_next_pc)
	);

	reg_file u_gpr (
		.clk(clk), .rst(rst), .rs1_addr(rs1_addr), .rs2_addr(rs2_addr),
		.rs1_data(rs1_data), .rs2_data(rs2_data),
		.wen(gpr_wen), .waddr(gpr_waddr), .wdata(gpr_wdata)
	);

	data_mem u_dmem (
		.clk(clk), .wen(mem_wen), .addr(mem_addr), .wmask(mem_wmask),
		.wdata(mem_wdata), .rdata(mem_rdata)
	);

endmodule

// File: testbench/exec_tb.sv
`timescale 1ns/1ns

module exec_tb;

	logic        clk = 1'b0;
	logic        rst;
	logic        inst_valid;
	logic [31:0] inst;
	logic [31:0] inst_pc;
	logic        inst_credit;
	logic        retire_valid;
	logic [31:0] retire_pc;
	logic [4:0]  retire_rd;
	logic        retire_wen;
	logic [31:0] retire_wdata;
	logic        retire_jump;
	logic [31:0] retire_next_pc;

	// reference state and the expected retire stream, indexed by send order.
	logic [31:0] ref_regs [32];
	logic [31:0] ref_mem [256];
	logic [31:0] exp_pc [512];
	logic [31:0] exp_wdata [512];
	logic [31:0] exp_next [512];
	logic [4:0]  exp_rd [512];
	logic        exp_wen [512];
	logic        exp_jump [512];

	int          credits;
	int          n_sent;
	int          ret_idx; // retires already checked.
	logic        pending;
	logic        quiet;
	logic        burst;
	logic        hung;
	logic [31:0] pc;
	int          val_errs;
	int          other_errs;

	exec_top dut (
		.clk(clk), .rst(rst), .inst_valid(inst_valid), .inst(inst), .inst_pc(inst_pc),
		.inst_credit(inst_credit), .retire_valid(retire_valid), .retire_pc(retire_pc),
		.retire_rd(retire_rd), .retire_wen(retire_wen), .retire_wdata(retire_wdata),
		.retire_jump(retire_jump), .retire_next_pc(retire_next_pc)
	);

	always #10 clk = ~clk;

	function automatic void value_fail(string name, logic [31:0] expv, logic [31:0] gotv);
		val_errs++;
		$display("FAIL %s expected %h actual %h", name, expv, gotv);
	endfunction

	function automatic void other_fail(string msg);
		other_errs++;
		$display("ERROR %s", msg);
	endfunction

	a_pc: assert property (@(posedge clk) disable iff (rst)
		retire_valid |-> retire_pc == exp_pc[9'(ret_idx)])
		else value_fail("retire_pc", exp_pc[9'(ret_idx)], $sampled(retire_pc));
	a_wdata: assert property (@(posedge clk) disable iff (rst)
		retire_valid |-> retire_wdata == exp_wdata[9'(ret_idx)])
		else value_fail("retire_wdata", exp_wdata[9'(ret_idx)], $sampled(retire_wdata));
	a_rd: assert property (@(posedge clk) disable iff (rst)
		retire_valid |-> retire_rd == exp_rd[9'(ret_idx)])
		else value_fail("retire_rd", 32'(exp_rd[9'(ret_idx)]), 32'($sampled(retire_rd)));
	a_wen: assert property (@(posedge clk) disable iff (rst)
		retire_valid |-> retire_wen == exp_wen[9'(ret_idx)])
		else value_fail("retire_wen", 32'(exp_wen[9'(ret_idx)]), 32'($sampled(retire_wen)));
	a_jump: assert property (@(posedge clk) disable iff (rst)
		retire_valid |-> retire_jump == exp_jump[9'(ret_idx)])
		else value_fail("retire_jump", 32'(exp_jump[9'(ret_idx)]), 32'($sampled(retire_jump)));
	a_next: assert property (@(posedge clk) disable iff (rst)
		retire_valid |-> retire_next_pc == exp_next[9'(ret_idx)])
		else value_fail("retire_next_pc", exp_next[9'(ret_idx)], $sampled(retire_next_pc));
	// one credit back for each popped entry.
	a_credit: assert property (@(posedge clk) disable iff (rst) inst_credit == retire_valid)
		else value_fail("inst_credit", 32'($sampled(retire_valid)), 32'($sampled(inst_credit)));
	a_spent: assert property (@(posedge clk) disable iff (rst) retire_valid |-> ret_idx < n_sent)
		else other_fail("retire seen with no instruction outstanding");
	a_limit: assert property (@(posedge clk) credits <= rv_exec_pkg::QUEUE_DEPTH)
		else other_fail("more credits returned than were spent");
	a_quiet: assert property (@(posedge clk) quiet |-> !retire_valid && !inst_credit)
		else other_fail("retire or credit activity right after reset");

	function automatic logic [31:0] enc_i(logic [11:0] imm, logic [4:0] rs1, logic [2:0] f3,
			logic [4:0] rd, logic [6:0] op);
		return {imm, rs1, f3, rd, op};
	endfunction

	function automatic logic [31:0] enc_r(logic [6:0] f7, logic [4:0] rs2, logic [4:0] rs1,
			logic [2:0] f3, logic [4:0] rd);
		return {f7, rs2, rs1, f3, rd, rv_exec_pkg::OP_R};
	endfunction

	function automatic logic [31:0] enc_s(logic [11:0] imm, logic [4:0] rs1, logic [4:0] rs2,
			logic [2:0] f3);
		return {imm[11:5], rs2, rs1, f3, imm[4:0], rv_exec_pkg::OP_S};
	endfunction

	function automatic logic [31:0] enc_b(logic [12:0] imm, logic [4:0] rs1, logic [4:0] rs2,
			logic [2:0] f3);
		return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], rv_exec_pkg::OP_B};
	endfunction

	function automatic logic [31:0] enc_j(logic [20:0] imm, logic [4:0] rd);
		return {imm[20], imm[10:1], imm[11], imm[19:12], rd, rv_exec_pkg::OP_J};
	endfunction

	function automatic logic [31:0] alu_ref(logic [2:0] f3, logic alt, logic [31:0] a,
			logic [31:0] b);
		case (f3)
			rv_exec_pkg::F3_ADDSUB: return alt ? a - b : a + b;
			rv_exec_pkg::F3_SLL:    return a << b[4:0];
			rv_exec_pkg::F3_SLT:    return {31'b0, $signed(a) < $signed(b)};
			rv_exec_pkg::F3_SLTU:   return {31'b0, a < b};
			rv_exec_pkg::F3_XOR:    return a ^ b;
			rv_exec_pkg::F3_SR: begin
				if (alt)
					return $signed(a) >>> b[4:0];
				return a >> b[4:0];
			end
			rv_exec_pkg::F3_OR:     return a | b;
			default:                return a & b;
		endcase
	endfunction

	function automatic logic taken_ref(logic [2:0] f3, logic [31:0] a, logic [31:0] b);
		case (f3)
			rv_exec_pkg::F3_BEQ:  return a == b;
			rv_exec_pkg::F3_BNE:  return a != b;
			rv_exec_pkg::F3_BLT:  return $signed(a) < $signed(b);
			rv_exec_pkg::F3_BGE:  return $signed(a) >= $signed(b);
			rv_exec_pkg::F3_BLTU: return a < b;
			rv_exec_pkg::F3_BGEU: return a >= b;
			default:              return 1'b0;
		endcase
	endfunction

	// executes one instruction word on the reference state.
	task automatic model(input logic [31:0] w, input logic [31:0] ipc);
		logic [6:0]  opc;
		logic [4:0]  rd;
		logic [2:0]  f3;
		logic [31:0] a;
		logic [31:0] b;
		logic [31:0] ii;
		logic [31:0] addr;
		logic [31:0] lane;
		logic [31:0] res;
		logic [31:0] nxt;
		logic [4:0]  sh;
		logic [7:0]  idx;
		logic        wr;
		logic        jmp;
		opc  = w[6:0];
		rd   = w[11:7];
		f3   = w[14:12];
		a    = ref_regs[w[19:15]];
		b    = ref_regs[w[24:20]];
		ii   = {{20{w[31]}}, w[31:20]};
		addr = a + ((opc == rv_exec_pkg::OP_S) ? {{20{w[31]}}, w[31:25], w[11:7]} : ii);
		idx  = addr[9:2];
		sh   = {addr[1:0], 3'b000};
		lane = ref_mem[idx] >> sh;
		res  = 32'd0;
		nxt  = ipc + 32'd4;
		wr   = 1'b1;
		jmp  = 1'b0;
		case (opc)
			rv_exec_pkg::OP_R: res = alu_ref(f3, w[30], a, b);
			rv_exec_pkg::OP_I: res = alu_ref(f3, f3 == rv_exec_pkg::F3_SR && w[30], a, ii);
			rv_exec_pkg::OP_IL: begin
				case (f3)
					rv_exec_pkg::F3_B:  res = {{24{lane[7]}}, lane[7:0]};
					rv_exec_pkg::F3_H:  res = {{16{lane[15]}}, lane[15:0]};
					rv_exec_pkg::F3_BU: res = {24'b0, lane[7:0]};
					rv_exec_pkg::F3_HU: res = {16'b0, lane[15:0]};
					default:            res = ref_mem[idx];
				endcase
			end
			rv_exec_pkg::OP_S: begin
				wr = 1'b0;
				case (f3)
					rv_exec_pkg::F3_B: ref_mem[idx][sh +: 8] = b[7:0];
					rv_exec_pkg::F3_H: ref_mem[idx][sh +: 16] = b[15:0];
					default:           ref_mem[idx] = b;
				endcase
			end
			rv_exec_pkg::OP_B: begin
				wr  = 1'b0;
				jmp = taken_ref(f3, a, b);
				if (jmp)
					nxt = ipc + {{19{w[31]}}, w[31], w[7], w[30:25], w[11:8], 1'b0};
			end
			rv_exec_pkg::OP_J: begin
				res = ipc + 32'd4;
				jmp = 1'b1;
				nxt = ipc + {{11{w[31]}}, w[31], w[19:12], w[20], w[30:21], 1'b0};
			end
			rv_exec_pkg::OP_JR: begin
				res = ipc + 32'd4;
				jmp = 1'b1;
				nxt = (a + ii) & ~32'd1;
			end
			rv_exec_pkg::OP_U:   res = {w[31:12], 12'b0};
			rv_exec_pkg::OP_UPC: res = ipc + {w[31:12], 12'b0};
			default:             wr = 1'b0;
		endcase
		if (wr && rd != 5'd0)
			ref_regs[rd] = res;
		exp_pc[9'(n_sent)]    = ipc;
		exp_wdata[9'(n_sent)] = res;
		exp_rd[9'(n_sent)]    = rd;
		exp_wen[9'(n_sent)]   = wr && rd != 5'd0;
		exp_jump[9'(n_sent)]  = jmp;
		exp_next[9'(n_sent)]  = nxt;
		n_sent++;
	endtask

	// one falling edge. returned credits and retires are counted here.
	task automatic tick();
		@(negedge clk);
		inst_valid = 1'b0;
		if (!rst) begin
			credits = credits + int'(inst_credit);
			ret_idx = ret_idx + int'(pending);
			pending = retire_valid;
		end
	endtask

	task automatic send(input logic [31:0] w);
		int t;
		if (hung)
			return;
		if (!burst && $urandom_range(3, 0) == 0)
			repeat ($urandom_range(3, 1)) tick();
		tick();
		t = 0;
		while (credits == 0 && !hung) begin
			tick();
			t++;
			if (t > 50) begin
				hung = 1'b1;
				other_fail("timeout waiting for a credit");
			end
		end
		if (hung)
			return;
		inst_valid = 1'b1;
		inst       = w;
		inst_pc    = pc;
		credits    = credits - 1;
		model(w, pc);
		pc = pc + 32'd4;
	endtask

	task automatic rand_alu();
		logic [4:0]  rd;
		logic [4:0]  rs1;
		logic [4:0]  rs2;
		logic [2:0]  f3;
		logic        alt;
		logic [11:0] imm;
		rd  = 5'($urandom_range(31, 0));
		rs1 = 5'($urandom_range(31, 0));
		rs2 = 5'($urandom_range(31, 0));
		f3  = 3'($urandom_range(7, 0));
		alt = 1'($urandom_range(1, 0));
		imm = 12'($urandom);
		if (f3 == rv_exec_pkg::F3_SLL || f3 == rv_exec_pkg::F3_SR)
			imm = {(alt && f3 == rv_exec_pkg::F3_SR) ? rv_exec_pkg::F7_ALT : 7'b0, imm[4:0]};
		case ($urandom_range(3, 0))
			0: send(enc_r((alt && (f3 == rv_exec_pkg::F3_ADDSUB || f3 == rv_exec_pkg::F3_SR)) ?
				rv_exec_pkg::F7_ALT : 7'b0, rs2, rs1, f3, rd));
			1: send(enc_i(imm, rs1, f3, rd, rv_exec_pkg::OP_I));
			2: send({20'($urandom), rd, rv_exec_pkg::OP_U});
			default: send({20'($urandom), rd, rv_exec_pkg::OP_UPC});
		endcase
	endtask

	initial begin
		int t;
		logic [2:0] f3;
		void'($urandom(67251));
		rst        = 1'b1;
		inst_valid = 1'b0;
		inst       = 32'd0;
		inst_pc    = 32'd0;
		credits    = rv_exec_pkg::QUEUE_DEPTH;
		n_sent     = 0;
		ret_idx    = 0;
		pending    = 1'b0;
		quiet      = 1'b0;
		burst      = 1'b0;
		hung       = 1'b0;
		pc         = 32'h0000_1000;
		val_errs   = 0;
		other_errs = 0;
		for (int r = 0; r < 32; r++)
			ref_regs[r] = 32'd0;
		for (int m = 0; m < 256; m++)
			ref_mem[m] = 32'd0;
		repeat (4) tick();
		rst   = 1'b0;
		quiet = 1'b1;
		repeat (3) tick();
		quiet = 1'b0;

		// every register reads back zero.
		for (int r = 1; r < 32; r++)
			send(enc_i(12'd0, 5'(r), rv_exec_pkg::F3_ADDSUB, 5'(r), rv_exec_pkg::OP_I));

		for (int r = 1; r < 16; r++) begin
			send({20'($urandom), 5'(r), rv_exec_pkg::OP_U});
			send(enc_i(12'($urandom), 5'(r), rv_exec_pkg::F3_ADDSUB, 5'(r), rv_exec_pkg::OP_I));
		end
		repeat (60) rand_alu();

		// two words at 0x100 filled by every store width, then read back.
		send(enc_i(12'h100, 5'd0, rv_exec_pkg::F3_ADDSUB, 5'd20, rv_exec_pkg::OP_I));
		send(enc_s(12'd0, 5'd20, 5'd5, rv_exec_pkg::F3_W));
		send(enc_s(12'd4, 5'd20, 5'd6, rv_exec_pkg::F3_W));
		send(enc_s(12'd1, 5'd20, 5'd7, rv_exec_pkg::F3_B));
		send(enc_s(12'd2, 5'd20, 5'd8, rv_exec_pkg::F3_H));
		send(enc_s(12'd7, 5'd20, 5'd9, rv_exec_pkg::F3_B));
		send(enc_s(12'd4, 5'd20, 5'd10, rv_exec_pkg::F3_H));
		for (int off = 0; off < 8; off++) begin
			send(enc_i(12'(off), 5'd20, rv_exec_pkg::F3_B, 5'd11, rv_exec_pkg::OP_IL));
			send(enc_i(12'(off), 5'd20, rv_exec_pkg::F3_BU, 5'd12, rv_exec_pkg::OP_IL));
		end
		for (int off = 0; off < 8; off += 2) begin
			send(enc_i(12'(off), 5'd20, rv_exec_pkg::F3_H, 5'd13, rv_exec_pkg::OP_IL));
			send(enc_i(12'(off), 5'd20, rv_exec_pkg::F3_HU, 5'd14, rv_exec_pkg::OP_IL));
		end
		send(enc_i(12'd0, 5'd20, rv_exec_pkg::F3_W, 5'd15, rv_exec_pkg::OP_IL));
		send(enc_i(12'd4, 5'd20, rv_exec_pkg::F3_W, 5'd0, rv_exec_pkg::OP_IL));
		send(enc_i(12'd8, 5'd20, rv_exec_pkg::F3_ADDSUB, 5'd21, rv_exec_pkg::OP_I));
		send(enc_i(12'hffc, 5'd21, rv_exec_pkg::F3_W, 5'd16, rv_exec_pkg::OP_IL));

		// x1 = 5, x2 = -3, x3 = 5 split signed and unsigned order.
		send(enc_i(12'd5, 5'd0, rv_exec_pkg::F3_ADDSUB, 5'd1, rv_exec_pkg::OP_I));
		send(enc_i(12'hffd, 5'd0, rv_exec_pkg::F3_ADDSUB, 5'd2, rv_exec_pkg::OP_I));
		send(enc_i(12'd5, 5'd0, rv_exec_pkg::F3_ADDSUB, 5'd3, rv_exec_pkg::OP_I));
		for (int c = 0; c < 6; c++) begin
			f3 = 3'(c < 2 ? c : c + 2);
			send(enc_b(13'h0010, 5'd1, 5'd3, f3));
			send(enc_b(13'h1ff8, 5'd1, 5'd2, f3));
			send(enc_b({8'($urandom), 4'($urandom), 1'b0}, 5'd2, 5'd1, f3));
		end
		send(enc_j({20'($urandom), 1'b0}, 5'd1));
		send(enc_j(21'h1ffff4, 5'd0));
		send(enc_i(12'd3, 5'd20, 3'b000, 5'd5, rv_exec_pkg::OP_JR)); // odd target.
		send(enc_i(12'hfff, 5'd1, 3'b000, 5'd0, rv_exec_pkg::OP_JR));

		burst = 1'b1;
		repeat (40) rand_alu();
		burst = 1'b0;

		t = 0;
		while (ret_idx + int'(pending) < n_sent && !hung) begin
			tick();
			t++;
			if (t > 100) begin
				hung = 1'b1;
				other_fail("timeout waiting for instructions to retire");
			end
		end
		repeat (2) tick();
		assert (ret_idx == n_sent)
			else other_fail("number of retires differs from instructions sent");
		assert (credits == rv_exec_pkg::QUEUE_DEPTH)
			else other_fail("not all credits came back");

		$display("value errors: %0d, other errors: %0d", val_errs, other_errs);
		if (val_errs == 0 && other_errs == 0) begin
			$display("Done: no errors");
		end else begin
			$display("Done: errors found");
		end
		$finish;
	end

endmodule

// File: rv_exec.f
src/rv_exec_pkg.sv
src/inst_decoder.sv
src/issue_queue.sv
src/alu.sv
src/reg_file.sv
src/data_mem.sv
src/exec_unit.sv
src/exec_top.sv
testbench/exec_tb.sv

// File: run.sh
#!/bin/sh
# Build and run the execute subsystem testbench with Verilator.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module exec_tb \
	-f rv_exec.f -Mdir obj_dir -o exec_tb_sim > build.log 2>&1
status=$?
if [ $status -ne 0 ]; then
	cat build.log
	echo "build failed with status $status"
	exit 1
fi

./obj_dir/exec_tb_sim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if grep -q "^Done: no errors$" sim.log; then
	exit 0
fi
exit 1
